// File: verilog/hostbus_pkg.sv
// shared bus polarities and register map; 16 registers of 16 bits, register 15 is read-only
package hostbus_pkg;

    // host bus signal levels
    localparam logic CS_ENABLED = 1'b0;     // chip select is active low
    localparam logic RNW_READ   = 1'b1;     // rd_nwr high = read, low = write

    // register map
    localparam int NUM_REGS     = 16;       // registers addressed by the bus
    localparam int REG_NUM_BITS = 4;        // width of a register number

    // register number on the bus
    typedef logic [REG_NUM_BITS-1:0] reg_num_t;

    // one register word
    // high byte = even byte (bytesel 0), low byte = odd byte (bytesel 1)
    typedef logic [15:0] reg_word_t;

    // read-only write counter lives at the top of the map
    localparam reg_num_t STATUS_REG = reg_num_t'(NUM_REGS - 1);

endpackage

// File: verilog/bus_interface.sv
// host must hold reg num, bytesel, rd_nwr and data stable for the whole chip select window; clk > 2x bus rate
`timescale 1ns/1ps

module bus_interface import hostbus_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    // asynchronous host bus
    input  logic        bus_cs_n_i,         // active low chip select
    input  logic        bus_rd_nwr_i,       // 1 = read, 0 = write
    input  reg_num_t    bus_reg_num_i,      // register number
    input  logic        bus_bytesel_i,      // 0 = even (high) byte, 1 = odd (low) byte
    input  logic [7:0]  bus_data_i,         // write data from host
    // synchronized access towards reg_access
    output logic        write_strobe_o,     // one cycle per write access
    output logic        read_strobe_o,      // one cycle per read access
    output reg_num_t    reg_num_o,
    output logic        bytesel_o,
    output logic [7:0]  bytedata_o
);

    // chip select history with the newest sample in bit 3
    logic [3:0] cs_r;

    // two-stage synchronizers where stage 1 samples the pad
    logic       read_s1, read_s2;
    logic       bytesel_s1, bytesel_s2;
    reg_num_t   reg_num_s1, reg_num_s2;
    logic [7:0] data_s1, data_s2;

    // two enabled samples after a disabled one
    // a lone enabled sample never forms this pattern
    logic       cs_edge;
    assign cs_edge = (cs_r[2:0] == 3'b110);

    // chip select history shifts toward bit 0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_r <= 4'b0000;
        end else begin
            cs_r <= {(bus_cs_n_i == CS_ENABLED), cs_r[3:1]};    // enabled flag enters at bit 3
        end
    end

    // payload synchronizers settle while the cs history fills
    always_ff @(posedge clk) begin
        read_s1    <= (bus_rd_nwr_i == RNW_READ);
        read_s2    <= read_s1;
        bytesel_s1 <= bus_bytesel_i;
        bytesel_s2 <= bytesel_s1;
        reg_num_s1 <= bus_reg_num_i;
        reg_num_s2 <= reg_num_s1;
        data_s1    <= bus_data_i;
        data_s2    <= data_s1;
    end

    // one-cycle strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            write_strobe_o <= cs_edge & ~read_s2;   // high only on the cs edge
            read_strobe_o  <= cs_edge & read_s2;
        end
    end

    // access fields registered alongside the strobe
    always_ff @(posedge clk) begin
        reg_num_o  <= reg_num_s2;
        bytesel_o  <= bytesel_s2;
        bytedata_o <= data_s2;
    end

    // host holds the access fields steady through the synchronizer stages
    a_fields_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        cs_edge |-> (read_s1 == read_s2) && (bytesel_s1 == bytesel_s2)
                    && (reg_num_s1 == reg_num_s2) && (data_s1 == data_s2)
    ) else $error("host changed access fields while chip select was enabled");

endmodule

// File: verilog/reg_access.sv
// even byte first for 16-bit accesses; odd write without a prior even write uses the last high byte
`timescale 1ns/1ps

module reg_access import hostbus_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    // byte accesses from bus_interface
    input  logic        write_strobe_i,
    input  logic        read_strobe_i,
    input  reg_num_t    reg_num_i,
    input  logic        bytesel_i,          // 0 = even/high, 1 = odd/low
    input  logic [7:0]  bytedata_i,
    // write port to reg_file
    output logic        wr_valid_o,
    input  logic        wr_ready_i,
    output reg_num_t    wr_num_o,
    output reg_word_t   wr_data_o,
    // read port to reg_file
    output reg_num_t    rd_num_o,
    input  reg_word_t   rd_data_i,          // combinational from reg_file
    // host read data
    output logic [7:0]  bus_data_o          // byte of the last read
);

    logic [7:0] hi_byte;        // latched even byte of a pending 16-bit write
    reg_word_t  rd_word;        // word captured by the even read
    logic       even_write;
    logic       odd_write;
    logic       wr_pending;     // request held back by reg_file
    logic       wr_xfer;

    assign even_write = write_strobe_i & ~bytesel_i;
    assign odd_write  = write_strobe_i & bytesel_i;
    assign wr_xfer    = wr_valid_o & wr_ready_i;
    assign wr_pending = wr_valid_o & ~wr_ready_i;

    assign rd_num_o = reg_num_i;    // reg_file reads the strobed register

    // high byte latch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_byte <= 8'h00;
        end else if (even_write) begin
            hi_byte <= bytedata_i;
        end
    end

    // write request valid flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_valid_o <= 1'b0;
        end else begin
            if (wr_xfer) begin
                wr_valid_o <= 1'b0;     // accepted by reg_file
            end
            if (odd_write && !wr_pending) begin
                wr_valid_o <= 1'b1;     // new word, may follow a transfer directly
            end
        end
    end

    // write request payload, held while pending
    always_ff @(posedge clk) begin
        if (odd_write && !wr_pending) begin
            wr_num_o  <= reg_num_i;
            wr_data_o <= {hi_byte, bytedata_i};     // even byte is the high byte
        end
    end

    // host read data
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_data_o <= 8'h00;
        end else if (read_strobe_i) begin
            if (!bytesel_i) begin
                bus_data_o <= rd_data_i[15:8];      // high byte straight from reg_file
            end else begin
                bus_data_o <= rd_word[7:0];         // low byte of the earlier capture
            end
        end
    end

    // captured word keeps the 16-bit read atomic
    always_ff @(posedge clk) begin
        if (read_strobe_i && !bytesel_i) begin
            rd_word <= rd_data_i;
        end
    end

    // a completed bus write must find the write port free
    a_no_write_overrun: assert property (
        @(posedge clk) disable iff (reset_i)
        !(odd_write && wr_pending)
    ) else $error("16-bit write dropped, previous write still pending");

endmodule

// File: verilog/reg_file.sv
// register 15 is a read-only write counter; writes to it are accepted but discarded
`timescale 1ns/1ps

module reg_file import hostbus_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    // write port
    input  logic        wr_valid_i,
    output logic        wr_ready_o,
    input  reg_num_t    wr_num_i,
    input  reg_word_t   wr_data_i,
    // combinational read port
    input  reg_num_t    rd_num_i,
    output reg_word_t   rd_data_o
);

    reg_word_t  regs [NUM_REGS-1];  // registers 0 .. 14
    reg_word_t  wr_count;           // writes accepted to 0 .. 14
    logic       wr_accept;
    logic       wr_store;           // accepted and not aimed at status

    assign wr_accept = wr_valid_i & wr_ready_o;
    assign wr_store  = wr_accept & (wr_num_i != STATUS_REG);

    // ready follows reset one cycle late
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ready_o <= 1'b0;
        end else begin
            wr_ready_o <= 1'b1;     // never stalls outside reset
        end
    end

    // storage cleared on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_store) begin
            regs[wr_num_i] <= wr_data_i;
        end
    end

    // status counter wraps at 16 bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_count <= '0;
        end else if (wr_store) begin
            wr_count <= wr_count + 16'd1;
        end
    end

    // read mux
    always_comb begin
        if (rd_num_i == STATUS_REG) begin
            rd_data_o = wr_count;
        end else begin
            rd_data_o = regs[rd_num_i];     // status index never reaches the array
        end
    end

    // requester keeps the write port idle while reset is held
    a_no_write_in_reset: assert property (
        @(posedge clk)
        (reset_i && $past(reset_i)) |-> !wr_valid_i
    ) else $error("write requested during reset");

endmodule

// File: verilog/hostbus_top.sv
// data out is a separate port, no tri-state pad; outputs change on clk, not on the host bus
`timescale 1ns/1ps

module hostbus_top import hostbus_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,
    input  logic        bus_rd_nwr_i,
    input  reg_num_t    bus_reg_num_i,
    input  logic        bus_bytesel_i,
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o      // byte of the last read
);

    // bus_interface to reg_access
    logic       write_strobe;
    logic       read_strobe;
    reg_num_t   reg_num;
    logic       bytesel;
    logic [7:0] bytedata;

    // reg_access to reg_file
    logic       wr_valid;
    logic       wr_ready;
    reg_num_t   wr_num;
    reg_word_t  wr_data;
    reg_num_t   rd_num;
    reg_word_t  rd_data;

    bus_interface u_bus_interface (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .bytesel_o      (bytesel),
        .bytedata_o     (bytedata)
    );

    reg_access u_reg_access (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .reg_num_i      (reg_num),
        .bytesel_i      (bytesel),
        .bytedata_i     (bytedata),
        .wr_valid_o     (wr_valid),
        .wr_ready_i     (wr_ready),
        .wr_num_o       (wr_num),
        .wr_data_o      (wr_data),
        .rd_num_o       (rd_num),
        .rd_data_i      (rd_data),
        .bus_data_o     (bus_data_o)
    );

    reg_file u_reg_file (
        .clk            (clk),
        .reset_i        (reset_i),
        .wr_valid_i     (wr_valid),
        .wr_ready_o     (wr_ready),
        .wr_num_i       (wr_num),
        .wr_data_i      (wr_data),
        .rd_num_i       (rd_num),
        .rd_data_o      (rd_data)
    );

endmodule

// File: verification/tb_hostbus_top.sv
// assumes 20 ns clk; each access holds chip select 8 cycles and idles 8 and reads always go even byte first
`timescale 1ns/1ps

module tb_hostbus_top import hostbus_pkg::*; ();

    // accesses per test for reset reads, write/read pairs, atomic reads, status and glitch
    localparam int NUM_ACCESSES   = 32 + 160 + 12 + 4 + 5;
    localparam int TIMEOUT_CYCLES = 200 * NUM_ACCESSES + 100;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    reg_num_t   bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;

    // reference model of the register file
    reg_word_t  model_regs [NUM_REGS-1];    // registers 0 .. 14
    reg_word_t  model_count;                // accepted writes to 0 .. 14
    reg_word_t  captured_word;              // word latched by the last even read

    integer     seed = 32'h25f03b03;
    int         cycle_count = 0;
    int         error_count = 0;
    int         check_count = 0;

    hostbus_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;      // 20 ns period

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // wait n edges and land 2 ns after the last one
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // one host access with chip select held 8 cycles
    task automatic run_access(input logic rd, input reg_num_t num, input logic bsel,
                              input logic [7:0] data, output logic [7:0] rdata);
        bus_rd_nwr_i  = rd ? RNW_READ : ~RNW_READ;
        bus_reg_num_i = num;
        bus_bytesel_i = bsel;
        bus_data_i    = data;
        wait_cycles(1);                 // payload stable before chip select
        bus_cs_n_i = CS_ENABLED;
        wait_cycles(8);
        bus_cs_n_i = ~CS_ENABLED;
        rdata = bus_data_o;             // settled since 5th edge
        wait_cycles(8);                 // idle gap
    endtask

    task automatic write_byte(input reg_num_t num, input logic bsel, input logic [7:0] data);
        logic [7:0] unused;
        run_access(1'b0, num, bsel, data, unused);
    endtask

    task automatic read_byte(input reg_num_t num, input logic bsel, output logic [7:0] data);
        run_access(1'b1, num, bsel, 8'h00, data);
    endtask

    // chip select low for a single sample only
    task automatic pulse_cs_once(input reg_num_t num, input logic [7:0] data);
        bus_rd_nwr_i  = ~RNW_READ;
        bus_reg_num_i = num;
        bus_bytesel_i = 1'b1;           // odd byte would complete a write
        bus_data_i    = data;
        wait_cycles(1);
        bus_cs_n_i = CS_ENABLED;
        wait_cycles(1);
        bus_cs_n_i = ~CS_ENABLED;
        wait_cycles(8);
    endtask

    function automatic reg_word_t model_word(input reg_num_t num);
        if (num == STATUS_REG) begin
            return model_count;
        end
        return model_regs[num];
    endfunction

    // expected read byte from model state
    function automatic logic [7:0] expected_byte(input reg_num_t num, input logic bsel);
        reg_word_t word;
        if (bsel) begin
            return captured_word[7:0];  // odd byte never rereads the register
        end
        word = model_word(num);
        return word[15:8];
    endfunction

    task automatic check_equal(input logic [7:0] got, input logic [7:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // read one byte and compare against the model
    task automatic read_check(input reg_num_t num, input logic bsel);
        logic [7:0] got;
        logic [7:0] exp;
        exp = expected_byte(num, bsel);
        read_byte(num, bsel, got);
        check_equal(got, exp, $sformatf("reg %0d byte %0d", num, bsel));
        if (!bsel) begin
            captured_word = model_word(num);    // mirror the atomic capture
        end
    endtask

    // 16-bit write with even byte first and model update
    task automatic write_word(input reg_num_t num, input reg_word_t data);
        write_byte(num, 1'b0, data[15:8]);
        write_byte(num, 1'b1, data[7:0]);
        if (num != STATUS_REG) begin
            model_regs[num] = data;
            model_count     = model_count + 16'd1;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        reg_num_t    num;
        reg_word_t   data;

        reset_i       = 1'b1;
        bus_cs_n_i    = ~CS_ENABLED;
        bus_rd_nwr_i  = RNW_READ;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        for (int i = 0; i < NUM_REGS - 1; i++) begin
            model_regs[i] = '0;
        end
        model_count   = '0;
        captured_word = '0;

        wait_cycles(10);
        reset_i = 1'b0;
        wait_cycles(2);

        // everything reads zero after reset
        for (int i = 0; i < NUM_REGS; i++) begin
            read_check(reg_num_t'(i), 1'b0);
            read_check(reg_num_t'(i), 1'b1);
        end

        // random 16-bit writes read back
        for (int i = 0; i < 40; i++) begin
            rnd  = $random(seed);
            num  = reg_num_t'(rnd % 15);
            rnd  = $random(seed);
            data = rnd[15:0];
            write_word(num, data);
            read_check(num, 1'b0);
            read_check(num, 1'b1);
        end

        // odd byte comes from the word captured before the rewrite
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            num = reg_num_t'(rnd % 15);
            read_check(num, 1'b0);
            data = {rnd[23:16], ~model_regs[num][7:0]};    // low byte always differs
            write_word(num, data);
            read_check(num, 1'b1);
        end

        // status register ignores writes and holds the write count
        write_word(STATUS_REG, 16'hbeef);
        read_check(STATUS_REG, 1'b0);
        read_check(STATUS_REG, 1'b1);

        // single-sample chip select is not an access
        num = reg_num_t'(4'd3);
        pulse_cs_once(num, ~model_regs[num][7:0]);
        read_check(num, 1'b0);
        read_check(num, 1'b1);
        read_check(STATUS_REG, 1'b0);
        read_check(STATUS_REG, 1'b1);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/hostbus_pkg.sv
verilog/bus_interface.sv
verilog/reg_access.sv
verilog/reg_file.sv
verilog/hostbus_top.sv
verification/tb_hostbus_top.sv

// File: Bender.yml
package:
  name: hostbus

sources:
  # rtl, package first
  - files:
      - verilog/hostbus_pkg.sv
      - verilog/bus_interface.sv
      - verilog/reg_access.sv
      - verilog/reg_file.sv
      - verilog/hostbus_top.sv

  # testbench
  - target: test
    files:
      - verification/tb_hostbus_top.sv
